//--- alu_pkg.sv
package alu_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int DATA_WIDTH     = 32;
    localparam int PC_WIDTH       = 32;
    localparam int ID_WIDTH       = 6;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int OPCODE_WIDTH   = 7;
    localparam int OFFSET_WIDTH   = 15;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////
    // Arithmetic and moves
    localparam logic [OPCODE_WIDTH-1:0] OP_ADD  = 7'h00;
    localparam logic [OPCODE_WIDTH-1:0] OP_SUB  = 7'h01;
    localparam logic [OPCODE_WIDTH-1:0] OP_SLL  = 7'h02;
    localparam logic [OPCODE_WIDTH-1:0] OP_SRL  = 7'h03;
    localparam logic [OPCODE_WIDTH-1:0] OP_ADDI = 7'h04;
    localparam logic [OPCODE_WIDTH-1:0] OP_MOV  = 7'h14;

    // Memory
    localparam logic [OPCODE_WIDTH-1:0] OP_LDB  = 7'h10;
    localparam logic [OPCODE_WIDTH-1:0] OP_LDW  = 7'h11;
    localparam logic [OPCODE_WIDTH-1:0] OP_STB  = 7'h12;
    localparam logic [OPCODE_WIDTH-1:0] OP_STW  = 7'h13;

    // Control flow, all compares unsigned
    localparam logic [OPCODE_WIDTH-1:0] OP_BEQ  = 7'h30;
    localparam logic [OPCODE_WIDTH-1:0] OP_BNE  = 7'h31;
    localparam logic [OPCODE_WIDTH-1:0] OP_BLT  = 7'h32;
    localparam logic [OPCODE_WIDTH-1:0] OP_BGT  = 7'h33;
    localparam logic [OPCODE_WIDTH-1:0] OP_BLE  = 7'h34;
    localparam logic [OPCODE_WIDTH-1:0] OP_BGE  = 7'h35;
    localparam logic [OPCODE_WIDTH-1:0] OP_JUMP = 7'h36;

    // Unlisted codes also act as NOP
    localparam logic [OPCODE_WIDTH-1:0] OP_NOP  = 7'h7f;

    ////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////
    // Register format
    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]   opcode;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [REG_ADDR_WIDTH-1:0] ra_addr;
        logic [REG_ADDR_WIDTH-1:0] rb_addr;
        logic [9:0]                pad;
    } alu_r_fmt_t;

    // Immediate format
    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]   opcode;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [REG_ADDR_WIDTH-1:0] ra_addr;
        logic [OFFSET_WIDTH-1:0]   offset;
    } alu_i_fmt_t;

    typedef union packed {
        alu_r_fmt_t r;
        alu_i_fmt_t i;
    } alu_instr_u;

    ////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////
    typedef struct packed {
        alu_instr_u            instr;
        logic [DATA_WIDTH-1:0] ra_data;
        logic [DATA_WIDTH-1:0] rb_data;
        logic [PC_WIDTH-1:0]   pc;
        logic [ID_WIDTH-1:0]   instr_id;
    } alu_req_t;

    // Executed operation waiting in the stage buffer
    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]   opcode;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [PC_WIDTH-1:0]       pc;
        logic [ID_WIDTH-1:0]       instr_id;
        logic [DATA_WIDTH-1:0]     result;
        logic [DATA_WIDTH-1:0]     store_data;
        logic [OFFSET_WIDTH-1:0]   offset;
        logic                      overflow;
        logic                      eq;
        logic                      lt;
    } exec_result_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0]       pc;
        logic [ID_WIDTH-1:0]       instr_id;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [DATA_WIDTH-1:0]     addr;
        logic [DATA_WIDTH-1:0]     data;
        logic                      is_store;
        logic                      is_byte;
    } dcache_req_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0]       pc;
        logic [ID_WIDTH-1:0]       instr_id;
        logic                      rf_wen;
        logic [REG_ADDR_WIDTH-1:0] rf_dest;
        logic [DATA_WIDTH-1:0]     rf_data;
        logic                      xcpt_overflow;
        logic                      mem_blocked;
    } wb_req_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0] target_pc;
    } branch_req_t;

endpackage

//--- alu_execute.sv
`timescale 1ns/1ps

module alu_execute import alu_pkg::*;
(
    input  alu_req_t     req,
    output exec_result_t result
);

// Shift amounts at or above this push every set bit out of the word
localparam logic [OFFSET_WIDTH-1:0] SHIFT_LIMIT = OFFSET_WIDTH'(DATA_WIDTH);

alu_instr_u                 instr;
logic [OPCODE_WIDTH-1:0]    opcode;
logic                       use_i_view;
logic [DATA_WIDTH-1:0]      ra_data;
logic [DATA_WIDTH-1:0]      rb_data;
logic [DATA_WIDTH-1:0]      offset_ext;

logic [DATA_WIDTH:0]        add_rr;
logic [DATA_WIDTH:0]        add_ri;
logic [DATA_WIDTH:0]        ld_addr;
logic [DATA_WIDTH:0]        st_addr;
logic [2*DATA_WIDTH-1:0]    shl_wide;
logic                       shl_overflow;

assign instr   = req.instr;
assign opcode  = instr.r.opcode;
assign ra_data = req.ra_data;
assign rb_data = req.rb_data;

////////////////////////////////////////
// Format selection
////////////////////////////////////////
always_comb
begin
    case (opcode)
        OP_ADD, OP_SUB, OP_MOV, OP_NOP:
            use_i_view = 1'b0;
        OP_ADDI, OP_SLL, OP_SRL,
        OP_LDW, OP_LDB, OP_STW, OP_STB,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLE, OP_BGE, OP_JUMP:
            use_i_view = 1'b1;
        default:
            use_i_view = 1'b0;
    endcase
end

assign offset_ext = {{(DATA_WIDTH-OFFSET_WIDTH){1'b0}}, instr.i.offset};

////////////////////////////////////////
// Datapath with one carry bit
////////////////////////////////////////
assign add_rr  = {1'b0, ra_data} + {1'b0, rb_data};
assign add_ri  = {1'b0, ra_data} + {1'b0, offset_ext};

// Loads index off ra, stores off rb
assign ld_addr = {1'b0, ra_data} + {1'b0, offset_ext};
assign st_addr = {1'b0, rb_data} + {1'b0, offset_ext};

assign shl_wide = {{DATA_WIDTH{1'b0}}, ra_data} << instr.i.offset;

// Long shifts lose bits past the wide vector too
assign shl_overflow = (shl_wide[2*DATA_WIDTH-1:DATA_WIDTH] != '0)
                    | ((instr.i.offset >= SHIFT_LIMIT) & (ra_data != '0));

////////////////////////////////////////
// Result
////////////////////////////////////////
always_comb
begin
    result            = '0;
    result.opcode     = opcode;
    // Both formats place rd at the same bits
    result.rd_addr    = instr.r.rd_addr;
    result.pc         = req.pc;
    result.instr_id   = req.instr_id;
    result.store_data = ra_data;
    result.offset     = use_i_view ? instr.i.offset : '0;

    // Branch conditions are derived later from these two
    result.eq         = (ra_data == rb_data);
    result.lt         = (ra_data <  rb_data);

    case (opcode)
        OP_ADD:
        begin
            result.result   = add_rr[DATA_WIDTH-1:0];
            result.overflow = add_rr[DATA_WIDTH];
        end
        OP_SUB:
            result.result = ra_data - rb_data;
        OP_ADDI:
        begin
            result.result   = add_ri[DATA_WIDTH-1:0];
            result.overflow = add_ri[DATA_WIDTH];
        end
        OP_SLL:
        begin
            result.result   = shl_wide[DATA_WIDTH-1:0];
            result.overflow = shl_overflow;
        end
        OP_SRL:
            result.result = ra_data >> instr.i.offset;
        OP_LDW, OP_LDB:
        begin
            result.result   = ld_addr[DATA_WIDTH-1:0];
            result.overflow = ld_addr[DATA_WIDTH];
        end
        OP_STW, OP_STB:
        begin
            result.result   = st_addr[DATA_WIDTH-1:0];
            result.overflow = st_addr[DATA_WIDTH];
        end
        OP_MOV:
            result.result = ra_data;
        default:
        begin
            // Branches, jump and NOP carry no data result
            result.result = '0;
        end
    endcase
end

endmodule

//--- alu_pipe_reg.sv
`timescale 1ns/1ps

module alu_pipe_reg import alu_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,

    // From execute
    input  logic         req_valid,
    input  logic         flush,
    input  exec_result_t result,

    // To dispatch
    output logic         held_valid,
    output exec_result_t held
);

logic capture;

// A flushed request is dropped at the edge
assign capture = req_valid & ~flush;

////////////////////////////////////////
// Stage registers
////////////////////////////////////////
always_ff @(posedge clock)
begin
    if (!rst_n)
        held_valid <= 1'b0;
    else
        held_valid <= capture;
end

// Payload only moves with a live request
always_ff @(posedge clock)
begin
    if (capture)
        held <= result;
end

////////////////////////////////////////
// Checks
////////////////////////////////////////
// Nothing accepted under flush may reach dispatch
a_flush_drops: assert property (
    @(posedge clock) disable iff (!rst_n)
    (req_valid && flush) |=> !held_valid
);

endmodule

//--- alu_dispatch.sv
`timescale 1ns/1ps

module alu_dispatch import alu_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,

    input  logic         held_valid,
    input  exec_result_t held,
    input  logic         dcache_ready,

    output logic         dcache_valid,
    output dcache_req_t  dcache_req,
    output logic         wb_valid,
    output wb_req_t      wb_req,
    output logic         take_branch,
    output branch_req_t  branch_req
);

logic is_mem;
logic is_store;
logic is_byte;
logic writes_rf;
logic branch_cond;
logic to_cache;

////////////////////////////////////////
// Opcode classes
////////////////////////////////////////
always_comb
begin
    is_mem      = 1'b0;
    is_store    = 1'b0;
    is_byte     = 1'b0;
    writes_rf   = 1'b0;
    branch_cond = 1'b0;

    case (held.opcode)
        OP_ADD, OP_SUB, OP_ADDI, OP_SLL, OP_SRL, OP_MOV:
            writes_rf = 1'b1;
        OP_LDW:
            is_mem = 1'b1;
        OP_LDB:
        begin
            is_mem  = 1'b1;
            is_byte = 1'b1;
        end
        OP_STW:
        begin
            is_mem   = 1'b1;
            is_store = 1'b1;
        end
        OP_STB:
        begin
            is_mem   = 1'b1;
            is_store = 1'b1;
            is_byte  = 1'b1;
        end
        OP_BEQ:  branch_cond = held.eq;
        OP_BNE:  branch_cond = ~held.eq;
        OP_BLT:  branch_cond = held.lt;
        OP_BGT:  branch_cond = ~held.lt & ~held.eq;
        OP_BLE:  branch_cond = held.lt | held.eq;
        OP_BGE:  branch_cond = ~held.lt;
        OP_JUMP: branch_cond = 1'b1;
        default: ;
    endcase
end

////////////////////////////////////////
// Routing
////////////////////////////////////////
// Overflow wins over the cache path
assign to_cache     = held_valid & ~held.overflow & is_mem & dcache_ready;

assign dcache_valid = to_cache;
// Write-back takes overflows, non-memory ops and blocked accesses
assign wb_valid     = held_valid & (held.overflow | ~is_mem | ~dcache_ready);
assign take_branch  = held_valid & branch_cond;

always_comb
begin
    dcache_req.pc       = held.pc;
    dcache_req.instr_id = held.instr_id;
    dcache_req.rd_addr  = held.rd_addr;
    dcache_req.addr     = held.result;
    dcache_req.data     = held.store_data;
    dcache_req.is_store = is_store;
    dcache_req.is_byte  = is_byte;
end

always_comb
begin
    wb_req.pc            = held.pc;
    wb_req.instr_id      = held.instr_id;
    wb_req.rf_wen        = writes_rf & ~held.overflow;
    wb_req.rf_dest       = held.rd_addr;
    wb_req.rf_data       = held.result;
    wb_req.xcpt_overflow = held.overflow;
    wb_req.mem_blocked   = is_mem & ~held.overflow & ~dcache_ready;
end

// Target is the offset, zero extended
assign branch_req.target_pc = {{(PC_WIDTH-OFFSET_WIDTH){1'b0}}, held.offset};

////////////////////////////////////////
// Checks
////////////////////////////////////////
a_one_route: assert property (
    @(posedge clock) disable iff (!rst_n)
    !(dcache_valid && wb_valid)
);

// A redirect always retires through write-back
a_branch_wb: assert property (
    @(posedge clock) disable iff (!rst_n)
    take_branch |-> wb_valid
);

endmodule

//--- alu_top.sv
`timescale 1ns/1ps

module alu_top import alu_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,

    // Request from decode
    input  logic        req_valid,
    input  alu_req_t    req,
    input  logic        flush,
    input  logic        dcache_ready,

    // Data cache
    output logic        dcache_valid,
    output dcache_req_t dcache_req,

    // Write-back
    output logic        wb_valid,
    output wb_req_t     wb_req,

    // Redirect to fetch
    output logic        take_branch,
    output branch_req_t branch_req
);

exec_result_t exec_result;
logic         held_valid;
exec_result_t held;

////////////////////////////////////////
// Execute, buffer, dispatch
////////////////////////////////////////
alu_execute u_execute (
    .req          (req),
    .result       (exec_result)
);

alu_pipe_reg u_pipe_reg (
    .clock        (clock),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .flush        (flush),
    .result       (exec_result),
    .held_valid   (held_valid),
    .held         (held)
);

alu_dispatch u_dispatch (
    .clock        (clock),
    .rst_n        (rst_n),
    .held_valid   (held_valid),
    .held         (held),
    .dcache_ready (dcache_ready),
    .dcache_valid (dcache_valid),
    .dcache_req   (dcache_req),
    .wb_valid     (wb_valid),
    .wb_req       (wb_req),
    .take_branch  (take_branch),
    .branch_req   (branch_req)
);

endmodule

//--- tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// One queue slot per driven cycle, live only when an output is due
typedef struct packed {
    logic     live;
    alu_req_t req;
} stim_t;

typedef struct packed {
    logic        dcache_valid;
    dcache_req_t dcache_req;
    logic        wb_valid;
    wb_req_t     wb_req;
    logic        take_branch;
    branch_req_t branch_req;
} alu_out_t;

////////////////////////////////////////
// Random source
////////////////////////////////////////
// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] random_bits(input int count);
    logic [31:0] bits;
    logic        feedback;
    bits = '0;
    for (int n = 0; n < count; n++)
    begin
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        bits       = {bits[30:0], feedback};
    end
    return bits;
endfunction

// Small, near the top of the range, or anything
function automatic logic [DATA_WIDTH-1:0] pick_operand();
    logic [1:0] kind;
    kind = 2'(random_bits(2));
    case (kind)
        2'd0:    return random_bits(8);
        2'd1:    return 32'hffff_ff00 | random_bits(8);
        default: return random_bits(32);
    endcase
endfunction

function automatic logic [OPCODE_WIDTH-1:0] pick_arith_op();
    logic [OPCODE_WIDTH-1:0] ops [7];
    ops = '{OP_ADD, OP_SUB, OP_ADDI, OP_SLL, OP_SRL, OP_MOV, OP_NOP};
    return ops[random_bits(3) % 7];
endfunction

function automatic logic [OPCODE_WIDTH-1:0] pick_mem_op();
    logic [OPCODE_WIDTH-1:0] ops [4];
    ops = '{OP_LDW, OP_LDB, OP_STW, OP_STB};
    return ops[random_bits(2)];
endfunction

// Every opcode plus one unassigned code
function automatic logic [OPCODE_WIDTH-1:0] pick_any_op();
    logic [OPCODE_WIDTH-1:0] ops [19];
    ops = '{OP_ADD, OP_SUB, OP_ADDI, OP_SLL, OP_SRL, OP_MOV, OP_NOP,
            OP_LDW, OP_LDB, OP_STW, OP_STB, OP_BEQ, OP_BNE, OP_BLT,
            OP_BGT, OP_BLE, OP_BGE, OP_JUMP, 7'h5a};
    return ops[random_bits(5) % 19];
endfunction

////////////////////////////////////////
// Instruction builders
////////////////////////////////////////
function automatic alu_instr_u build_r(input logic [OPCODE_WIDTH-1:0] op,
                                       input logic [REG_ADDR_WIDTH-1:0] rd,
                                       input logic [REG_ADDR_WIDTH-1:0] ra,
                                       input logic [REG_ADDR_WIDTH-1:0] rb);
    alu_instr_u w;
    w.r.opcode  = op;
    w.r.rd_addr = rd;
    w.r.ra_addr = ra;
    w.r.rb_addr = rb;
    w.r.pad     = '0;
    return w;
endfunction

function automatic alu_instr_u build_i(input logic [OPCODE_WIDTH-1:0] op,
                                       input logic [REG_ADDR_WIDTH-1:0] rd,
                                       input logic [REG_ADDR_WIDTH-1:0] ra,
                                       input logic [OFFSET_WIDTH-1:0]   off);
    alu_instr_u w;
    w.i.opcode  = op;
    w.i.rd_addr = rd;
    w.i.ra_addr = ra;
    w.i.offset  = off;
    return w;
endfunction

function automatic alu_req_t random_request(input logic [OPCODE_WIDTH-1:0] op);
    alu_req_t                  r;
    logic [OFFSET_WIDTH-1:0]   off;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] ra;
    logic [REG_ADDR_WIDTH-1:0] rb;
    rd = REG_ADDR_WIDTH'(random_bits(5));
    ra = REG_ADDR_WIDTH'(random_bits(5));
    rb = REG_ADDR_WIDTH'(random_bits(5));
    // Shifts get short amounts half of the time
    if ((op == OP_SLL || op == OP_SRL) && random_bits(1) == 32'd1)
        off = OFFSET_WIDTH'(random_bits(6));
    else
        off = OFFSET_WIDTH'(random_bits(15));
    if (op == OP_ADD || op == OP_SUB || op == OP_MOV || op == OP_NOP)
        r.instr = build_r(op, rd, ra, rb);
    else
        r.instr = build_i(op, rd, ra, off);
    r.ra_data  = pick_operand();
    r.rb_data  = pick_operand();
    r.pc       = random_bits(32);
    r.instr_id = ID_WIDTH'(random_bits(6));
    return r;
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////
// True when a left shift pushes a set bit past the word
function automatic logic sll_loses_bits(input logic [DATA_WIDTH-1:0] a,
                                        input logic [DATA_WIDTH-1:0] amount);
    if (a == '0 || amount == '0)
        return 1'b0;
    if (amount >= DATA_WIDTH)
        return 1'b1;
    return (a >> (DATA_WIDTH - amount)) != '0;
endfunction

function automatic alu_out_t expected_outputs(input stim_t s, input logic ready);
    alu_out_t                o;
    logic [OPCODE_WIDTH-1:0] op;
    logic [DATA_WIDTH-1:0]   a;
    logic [DATA_WIDTH-1:0]   b;
    logic [DATA_WIDTH-1:0]   off;
    logic [DATA_WIDTH-1:0]   value;
    logic                    ovf;
    logic                    mem;
    logic                    store;
    logic                    byte_op;
    logic                    writes;
    logic                    cond;
    o       = '0;
    op      = s.req.instr.r.opcode;
    a       = s.req.ra_data;
    b       = s.req.rb_data;
    off     = DATA_WIDTH'(s.req.instr.i.offset);
    value   = '0;
    ovf     = 1'b0;
    mem     = 1'b0;
    store   = 1'b0;
    byte_op = 1'b0;
    writes  = 1'b0;
    cond    = 1'b0;
    case (op)
        OP_ADD:
        begin
            {ovf, value} = {1'b0, a} + {1'b0, b};
            writes       = 1'b1;
        end
        OP_SUB:
        begin
            value  = a - b;
            writes = 1'b1;
        end
        OP_ADDI:
        begin
            {ovf, value} = {1'b0, a} + {1'b0, off};
            writes       = 1'b1;
        end
        OP_SLL:
        begin
            value  = a << off;
            ovf    = sll_loses_bits(a, off);
            writes = 1'b1;
        end
        OP_SRL:
        begin
            value  = a >> off;
            writes = 1'b1;
        end
        OP_MOV:
        begin
            value  = a;
            writes = 1'b1;
        end
        OP_LDW, OP_LDB:
        begin
            {ovf, value} = {1'b0, a} + {1'b0, off};
            mem          = 1'b1;
            byte_op      = (op == OP_LDB);
        end
        OP_STW, OP_STB:
        begin
            {ovf, value} = {1'b0, b} + {1'b0, off};
            mem          = 1'b1;
            store        = 1'b1;
            byte_op      = (op == OP_STB);
        end
        OP_BEQ:  cond = (a == b);
        OP_BNE:  cond = (a != b);
        OP_BLT:  cond = (a < b);
        OP_BGT:  cond = (a > b);
        OP_BLE:  cond = (a <= b);
        OP_BGE:  cond = (a >= b);
        OP_JUMP: cond = 1'b1;
        default: ;
    endcase
    if (!s.live)
        return o;
    o.take_branch          = cond;
    o.branch_req.target_pc = PC_WIDTH'(s.req.instr.i.offset);
    if (!ovf && mem && ready)
    begin
        o.dcache_valid        = 1'b1;
        o.dcache_req.pc       = s.req.pc;
        o.dcache_req.instr_id = s.req.instr_id;
        o.dcache_req.rd_addr  = s.req.instr.r.rd_addr;
        o.dcache_req.addr     = value;
        o.dcache_req.data     = a;
        o.dcache_req.is_store = store;
        o.dcache_req.is_byte  = byte_op;
    end
    else
    begin
        o.wb_valid             = 1'b1;
        o.wb_req.pc            = s.req.pc;
        o.wb_req.instr_id      = s.req.instr_id;
        o.wb_req.rf_wen        = writes & ~ovf;
        o.wb_req.rf_dest       = s.req.instr.r.rd_addr;
        o.wb_req.rf_data       = value;
        o.wb_req.xcpt_overflow = ovf;
        o.wb_req.mem_blocked   = mem & ~ovf & ~ready;
    end
    return o;
endfunction

`endif

//--- tb_alu_top.sv
`timescale 1ns/1ps

module tb_alu_top import alu_pkg::*;
();

localparam int CHECK_DELAY = 75;
localparam int DRAIN_LIMIT = 20;

logic        clock;
logic        rst_n;
logic        req_valid;
alu_req_t    req;
logic        flush;
logic        dcache_ready;
logic        dcache_valid;
dcache_req_t dcache_req;
logic        wb_valid;
wb_req_t     wb_req;
logic        take_branch;
branch_req_t branch_req;

logic [31:0] lfsr_state = 32'hc12c;
int          errors = 0;
int          checks = 0;
int          in_flight = 0;

`include "tb_alu_model.svh"

stim_t pending[$];

alu_top DUT (
    .clock        (clock),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req          (req),
    .flush        (flush),
    .dcache_ready (dcache_ready),
    .dcache_valid (dcache_valid),
    .dcache_req   (dcache_req),
    .wb_valid     (wb_valid),
    .wb_req       (wb_req),
    .take_branch  (take_branch),
    .branch_req   (branch_req)
);

initial
begin
    clock = 1'b0;
    forever #50 clock = ~clock;
end

////////////////////////////////////////
// Checking
////////////////////////////////////////
task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] got,
                           input logic [DATA_WIDTH-1:0] want);
    checks++;
    if (got !== want)
    begin
        errors++;
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
    end
endtask

task automatic compare_outputs(input stim_t s);
    alu_out_t want;
    want = expected_outputs(s, dcache_ready);
    check_value("dcache_valid", DATA_WIDTH'(dcache_valid), DATA_WIDTH'(want.dcache_valid));
    check_value("wb_valid", DATA_WIDTH'(wb_valid), DATA_WIDTH'(want.wb_valid));
    check_value("take_branch", DATA_WIDTH'(take_branch), DATA_WIDTH'(want.take_branch));
    if (want.dcache_valid)
    begin
        check_value("dcache pc", dcache_req.pc, want.dcache_req.pc);
        check_value("dcache id", DATA_WIDTH'(dcache_req.instr_id),
                    DATA_WIDTH'(want.dcache_req.instr_id));
        check_value("dcache rd", DATA_WIDTH'(dcache_req.rd_addr),
                    DATA_WIDTH'(want.dcache_req.rd_addr));
        check_value("dcache addr", dcache_req.addr, want.dcache_req.addr);
        check_value("dcache data", dcache_req.data, want.dcache_req.data);
        check_value("is_store", DATA_WIDTH'(dcache_req.is_store),
                    DATA_WIDTH'(want.dcache_req.is_store));
        check_value("is_byte", DATA_WIDTH'(dcache_req.is_byte),
                    DATA_WIDTH'(want.dcache_req.is_byte));
    end
    if (want.wb_valid)
    begin
        check_value("wb pc", wb_req.pc, want.wb_req.pc);
        check_value("wb id", DATA_WIDTH'(wb_req.instr_id), DATA_WIDTH'(want.wb_req.instr_id));
        check_value("rf_wen", DATA_WIDTH'(wb_req.rf_wen), DATA_WIDTH'(want.wb_req.rf_wen));
        check_value("rf_dest", DATA_WIDTH'(wb_req.rf_dest), DATA_WIDTH'(want.wb_req.rf_dest));
        check_value("rf_data", wb_req.rf_data, want.wb_req.rf_data);
        check_value("xcpt_overflow", DATA_WIDTH'(wb_req.xcpt_overflow),
                    DATA_WIDTH'(want.wb_req.xcpt_overflow));
        check_value("mem_blocked", DATA_WIDTH'(wb_req.mem_blocked),
                    DATA_WIDTH'(want.wb_req.mem_blocked));
    end
    if (want.take_branch)
        check_value("target_pc", branch_req.target_pc, want.branch_req.target_pc);
endtask

// The slot captured at this edge is checked once dcache_ready has been driven for the cycle
always @(posedge clock)
begin
    stim_t slot;
    logic  taken;
    slot  = '0;
    taken = 1'b0;
    if (rst_n)
    begin
        if (pending.size() != 0)
        begin
            slot  = pending.pop_front();
            taken = 1'b1;
        end
        #(CHECK_DELAY);
        compare_outputs(slot);
        if (taken)
            in_flight--;
    end
end

////////////////////////////////////////
// Stimulus
////////////////////////////////////////
task automatic issue(input logic valid, input logic kill, input alu_req_t r);
    stim_t s;
    @(negedge clock);
    req_valid    = valid;
    flush        = kill;
    req          = r;
    dcache_ready = random_bits(1) == 32'd1;
    s.live       = valid & ~kill;
    s.req        = r;
    pending.push_back(s);
    in_flight++;
endtask

task automatic run_branches();
    logic [OPCODE_WIDTH-1:0] ops [6];
    alu_req_t                r;
    logic [DATA_WIDTH-1:0]   base;
    ops = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLE, OP_BGE};
    for (int k = 0; k < 6; k++)
    begin
        // Equal, ra below rb, ra above rb
        for (int rel = 0; rel < 3; rel++)
        begin
            r         = random_request(ops[k]);
            base      = random_bits(30) + 32'h100;
            r.ra_data = base;
            r.rb_data = base;
            if (rel == 1)
                r.rb_data = base + random_bits(8) + 1;
            if (rel == 2)
                r.ra_data = base + random_bits(8) + 1;
            issue(1'b1, 1'b0, r);
        end
    end
    repeat (4) issue(1'b1, 1'b0, random_request(OP_JUMP));
endtask

initial
begin
    int waited;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    flush        = 1'b0;
    req          = '0;
    dcache_ready = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;

    repeat (6) issue(1'b0, 1'b0, random_request(OP_NOP));
    repeat (200) issue(1'b1, 1'b0, random_request(pick_arith_op()));
    repeat (150) issue(1'b1, 1'b0, random_request(pick_mem_op()));
    run_branches();
    // Back to back with gaps and flushed slots
    repeat (300)
        issue(random_bits(3) != 32'd0, random_bits(2) == 32'd0, random_request(pick_any_op()));
    repeat (4) issue(1'b0, 1'b0, random_request(OP_NOP));

    waited = 0;
    while (in_flight != 0 && waited < DRAIN_LIMIT)
    begin
        @(posedge clock);
        waited++;
    end
    if (in_flight != 0)
        $display("Timed out with %0d results never checked", in_flight);
    $display("Closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && in_flight == 0)
        $display("=== PASS ===");
    else
        $display("=== FAIL ===");
    $finish;
end

endmodule

//--- compile.f
+incdir+.
alu_pkg.sv
alu_execute.sv
alu_pipe_reg.sv
alu_dispatch.sv
alu_top.sv
tb_alu_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_alu_top -f compile.f \
    && ./obj_dir/Vtb_alu_top | tee /dev/stderr | grep -qF "=== PASS ===" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
